// File: source/noc_pkg.sv
package noc_pkg;

    ////////////////////////////////////////////////////////////
    // Router geometry and flit format
    ////////////////////////////////////////////////////////////

    // Local port plus the four mesh neighbours.
    localparam int CHANNEL_NUMBER = 5;

    localparam int FLIT_DATA_W = 32;

    // One mesh coordinate in a header flit.
    localparam int COORD_W = 4;

    // Target fields inside the header flit data.
    localparam int HDR_X_LSB = 0;
    localparam int HDR_Y_LSB = 4;

    // A flit is data plus the end-of-packet marker.
    typedef struct packed {
        logic [FLIT_DATA_W-1:0] data;
        logic                   last;
    } flit_t;

    ////////////////////////////////////////////////////////////
    // Port indices
    ////////////////////////////////////////////////////////////

    // Same order on the input and on the output side.
    typedef enum logic [2:0] {
        PORT_LOCAL = 3'd0,
        PORT_NORTH = 3'd1,
        PORT_EAST  = 3'd2,
        PORT_SOUTH = 3'd3,
        PORT_WEST  = 3'd4
    } port_e;

endpackage

// File: source/flit_buffer.sv
module flit_buffer #(
    parameter int BUFFER_LENGTH = 4
) (
    input  logic           clk,
    input  logic           arst_n_i,

    input  noc_pkg::flit_t flit_i,
    input  logic           valid_i,
    output logic           ready_o,

    output noc_pkg::flit_t flit_o,
    output logic           valid_o,
    input  logic           ready_i
);

    import noc_pkg::*;

    localparam int PTR_W = (BUFFER_LENGTH > 1) ? $clog2(BUFFER_LENGTH) : 1;
    localparam int CNT_W = $clog2(BUFFER_LENGTH + 1);

    flit_t            mem [BUFFER_LENGTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(BUFFER_LENGTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push    = valid_i && ready_o;
    assign pop     = valid_o && ready_i;
    assign ready_o = (count != CNT_W'(BUFFER_LENGTH));
    assign valid_o = (count != '0);
    assign flit_o  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= flit_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound : assert property (@(posedge clk) disable iff (!arst_n_i)
        count <= CNT_W'(BUFFER_LENGTH))
        else $error("flit_buffer occupancy above BUFFER_LENGTH");

    // A stalled head flit must not move.
    a_head_stable : assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(flit_o))
        else $error("flit_buffer head changed while stalled");

endmodule

// File: source/packet_arbiter.sv
module packet_arbiter (
    input  logic                               clk,
    input  logic                               arst_n_i,

    input  noc_pkg::flit_t                     buf_flit_i [noc_pkg::CHANNEL_NUMBER],
    input  logic [noc_pkg::CHANNEL_NUMBER-1:0] buf_valid_i,
    output logic [noc_pkg::CHANNEL_NUMBER-1:0] buf_ready_o,

    output noc_pkg::flit_t                     arb_flit_o,
    output logic                               arb_valid_o,
    input  logic                               arb_ready_i,

    output logic [noc_pkg::COORD_W-1:0]        target_x_o,
    output logic [noc_pkg::COORD_W-1:0]        target_y_o
);

    import noc_pkg::*;

    localparam int IDX_W = $clog2(CHANNEL_NUMBER);

    logic [CHANNEL_NUMBER-1:0] grant;
    logic [IDX_W-1:0]          last_idx;
    logic                      is_header;
    logic                      busy;
    logic                      xfer;
    logic                      pick_found;
    logic [IDX_W-1:0]          pick_idx;
    logic [COORD_W-1:0]        target_x_q;
    logic [COORD_W-1:0]        target_y_q;

    ////////////////////////////////////////////////////////////
    // Round-robin search
    ////////////////////////////////////////////////////////////

    // Starts at the port after the last grant.
    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_idx   = last_idx;
        for (int k = 1; k <= CHANNEL_NUMBER; k++) begin
            idx = (int'(last_idx) + k) % CHANNEL_NUMBER;
            if (!pick_found && buf_valid_i[idx]) begin
                pick_found = 1'b1;
                pick_idx   = IDX_W'(idx);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Grant and stream multiplexer
    ////////////////////////////////////////////////////////////

    assign busy = |grant;

    // While busy, last_idx is the granted port.
    assign arb_flit_o  = buf_flit_i[last_idx];
    assign arb_valid_o = busy && buf_valid_i[last_idx];
    assign buf_ready_o = grant & {CHANNEL_NUMBER{arb_ready_i}};
    assign xfer        = arb_valid_o && arb_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            grant     <= '0;
            last_idx  <= IDX_W'(PORT_WEST);
            is_header <= 1'b0;
        end else if (!busy) begin
            if (pick_found) begin
                grant     <= CHANNEL_NUMBER'(1) << pick_idx;
                last_idx  <= pick_idx;
                is_header <= 1'b1;
            end
        end else if (xfer) begin
            is_header <= 1'b0;
            if (arb_flit_o.last) begin
                grant <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Target capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (xfer && is_header) begin
            target_x_q <= arb_flit_o.data[HDR_X_LSB +: COORD_W];
            target_y_q <= arb_flit_o.data[HDR_Y_LSB +: COORD_W];
        end
    end

    // Straight from the header, then held for the body flits.
    assign target_x_o = is_header ? arb_flit_o.data[HDR_X_LSB +: COORD_W] : target_x_q;
    assign target_y_o = is_header ? arb_flit_o.data[HDR_Y_LSB +: COORD_W] : target_y_q;

    a_grant_onehot : assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(grant))
        else $error("packet_arbiter grant is not one-hot");

    a_grant_hold : assert property (@(posedge clk) disable iff (!arst_n_i)
        busy && !(xfer && arb_flit_o.last) |=> grant == $past(grant))
        else $error("packet_arbiter grant changed inside a packet");

endmodule

// File: source/xy_routing.sv
module xy_routing #(
    parameter int ROUTER_X      = 0,
    parameter int ROUTER_Y      = 0,
    parameter int MAX_ROUTERS_X = 4,
    parameter int MAX_ROUTERS_Y = 4
) (
    input  logic                               clk,
    input  logic                               arst_n_i,

    input  noc_pkg::flit_t                     arb_flit_i,
    input  logic                               arb_valid_i,
    output logic                               arb_ready_o,
    input  logic [noc_pkg::COORD_W-1:0]        target_x_i,
    input  logic [noc_pkg::COORD_W-1:0]        target_y_i,

    output noc_pkg::flit_t                     out_flit_o [noc_pkg::CHANNEL_NUMBER],
    output logic [noc_pkg::CHANNEL_NUMBER-1:0] out_valid_o,
    input  logic [noc_pkg::CHANNEL_NUMBER-1:0] out_ready_i
);

    import noc_pkg::*;

    localparam logic [COORD_W-1:0] OWN_X = COORD_W'(ROUTER_X);
    localparam logic [COORD_W-1:0] OWN_Y = COORD_W'(ROUTER_Y);

    port_e route;

    ////////////////////////////////////////////////////////////
    // Dimension-ordered decision
    ////////////////////////////////////////////////////////////

    // X is resolved first, Y only once the column matches.
    always_comb begin
        if (target_x_i > OWN_X) begin
            route = PORT_EAST;
        end else if (target_x_i < OWN_X) begin
            route = PORT_WEST;
        end else if (target_y_i > OWN_Y) begin
            route = PORT_NORTH;
        end else if (target_y_i < OWN_Y) begin
            route = PORT_SOUTH;
        end else begin
            route = PORT_LOCAL;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output steering
    ////////////////////////////////////////////////////////////

    // Data goes everywhere, valid only to the chosen port.
    for (genvar j = 0; j < CHANNEL_NUMBER; j++) begin : g_out
        assign out_flit_o[j] = arb_flit_i;
    end

    always_comb begin
        out_valid_o        = '0;
        out_valid_o[route] = arb_valid_i;
    end

    assign arb_ready_o = out_ready_i[route];

    a_valid_onehot : assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(out_valid_o))
        else $error("xy_routing drives more than one output");

    // The header decides where the packet lands in the mesh.
    a_target_range : assert property (@(posedge clk) disable iff (!arst_n_i)
        arb_valid_i |-> (int'(target_x_i) < MAX_ROUTERS_X) &&
                        (int'(target_y_i) < MAX_ROUTERS_Y))
        else $error("xy_routing target outside the mesh");

endmodule

// File: source/noc_router.sv
module noc_router #(
    parameter int BUFFER_LENGTH = 4,
    parameter int ROUTER_X      = 0,
    parameter int ROUTER_Y      = 0,
    parameter int MAX_ROUTERS_X = 4,
    parameter int MAX_ROUTERS_Y = 4
) (
    input  logic                               clk,
    input  logic                               arst_n_i,

    input  noc_pkg::flit_t                     in_flit_i [noc_pkg::CHANNEL_NUMBER],
    input  logic [noc_pkg::CHANNEL_NUMBER-1:0] in_valid_i,
    output logic [noc_pkg::CHANNEL_NUMBER-1:0] in_ready_o,

    output noc_pkg::flit_t                     out_flit_o [noc_pkg::CHANNEL_NUMBER],
    output logic [noc_pkg::CHANNEL_NUMBER-1:0] out_valid_o,
    input  logic [noc_pkg::CHANNEL_NUMBER-1:0] out_ready_i
);

    import noc_pkg::*;

    flit_t                     buf_flit [CHANNEL_NUMBER];
    logic [CHANNEL_NUMBER-1:0] buf_valid;
    logic [CHANNEL_NUMBER-1:0] buf_ready;

    flit_t                     arb_flit;
    logic                      arb_valid;
    logic                      arb_ready;
    logic [COORD_W-1:0]        target_x;
    logic [COORD_W-1:0]        target_y;

    // One input FIFO per port.
    for (genvar i = 0; i < CHANNEL_NUMBER; i++) begin : g_buf
        flit_buffer #(
            .BUFFER_LENGTH(BUFFER_LENGTH)
        ) u_buf (
            .clk     (clk),
            .arst_n_i(arst_n_i),
            .flit_i  (in_flit_i[i]),
            .valid_i (in_valid_i[i]),
            .ready_o (in_ready_o[i]),
            .flit_o  (buf_flit[i]),
            .valid_o (buf_valid[i]),
            .ready_i (buf_ready[i])
        );
    end

    packet_arbiter u_arb (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .buf_flit_i (buf_flit),
        .buf_valid_i(buf_valid),
        .buf_ready_o(buf_ready),
        .arb_flit_o (arb_flit),
        .arb_valid_o(arb_valid),
        .arb_ready_i(arb_ready),
        .target_x_o (target_x),
        .target_y_o (target_y)
    );

    xy_routing #(
        .ROUTER_X     (ROUTER_X),
        .ROUTER_Y     (ROUTER_Y),
        .MAX_ROUTERS_X(MAX_ROUTERS_X),
        .MAX_ROUTERS_Y(MAX_ROUTERS_Y)
    ) u_route (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .arb_flit_i (arb_flit),
        .arb_valid_i(arb_valid),
        .arb_ready_o(arb_ready),
        .target_x_i (target_x),
        .target_y_i (target_y),
        .out_flit_o (out_flit_o),
        .out_valid_o(out_valid_o),
        .out_ready_i(out_ready_i)
    );

endmodule

// File: test/tb_noc_router.sv
module tb_noc_router;

    import noc_pkg::*;

    localparam int BUFFER_LENGTH  = 4;
    localparam int ROUTER_X       = 1;
    localparam int ROUTER_Y       = 2;
    localparam int MAX_ROUTERS_X  = 4;
    localparam int MAX_ROUTERS_Y  = 4;
    localparam int RANDOM_PACKETS = 30;
    localparam int FAIR_PACKETS   = 8;
    // Directed, random and fair packets of up to 6 flits at 8 cycles each, plus reset margin.
    localparam int TIMEOUT_CYCLES =
        (10 + CHANNEL_NUMBER * (RANDOM_PACKETS + FAIR_PACKETS)) * 6 * 8 + 400;

    logic                      clk;
    logic                      arst_n_i;
    flit_t                     in_flit_i [CHANNEL_NUMBER];
    logic [CHANNEL_NUMBER-1:0] in_valid_i;
    logic [CHANNEL_NUMBER-1:0] in_ready_o;
    flit_t                     out_flit_o [CHANNEL_NUMBER];
    logic [CHANNEL_NUMBER-1:0] out_valid_o;
    logic [CHANNEL_NUMBER-1:0] out_ready_i;

    // One expected queue per output and source pair.
    flit_t       exp_q [CHANNEL_NUMBER*CHANNEL_NUMBER][$];
    int          accepted [CHANNEL_NUMBER];
    int          delivered [CHANNEL_NUMBER];
    int          pkt_count [CHANNEL_NUMBER];
    int          cur_src [CHANNEL_NUMBER];
    logic        mid [CHANNEL_NUMBER];
    logic [15:0] tx_seq [CHANNEL_NUMBER];
    logic [15:0] rx_seq [CHANNEL_NUMBER];
    int          pending_flits;
    int          cycles;
    int          ready_mode;
    logic        fair_check;
    int          fair_prev;
    logic [31:0] rng_state = 32'h6aea_c59a;

    noc_router #(
        .BUFFER_LENGTH(BUFFER_LENGTH),
        .ROUTER_X     (ROUTER_X),
        .ROUTER_Y     (ROUTER_Y),
        .MAX_ROUTERS_X(MAX_ROUTERS_X),
        .MAX_ROUTERS_Y(MAX_ROUTERS_Y)
    ) DUT (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .in_flit_i  (in_flit_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .out_flit_o (out_flit_o),
        .out_valid_o(out_valid_o),
        .out_ready_i(out_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() % 32'(n));
    endfunction

    // XY rule with X resolved first.
    function automatic port_e expected_port(input logic [3:0] tx, input logic [3:0] ty);
        if (int'(tx) > ROUTER_X) return PORT_EAST;
        if (int'(tx) < ROUTER_X) return PORT_WEST;
        if (int'(ty) > ROUTER_Y) return PORT_NORTH;
        if (int'(ty) < ROUTER_Y) return PORT_SOUTH;
        return PORT_LOCAL;
    endfunction

    task automatic drive_flit(input int p, input flit_t f, input int gap);
        if (gap > 0) begin
            #1;
            in_valid_i[p] = 1'b0;
            repeat (gap) @(posedge clk);
        end
        #1;
        in_flit_i[p]  = f;
        in_valid_i[p] = 1'b1;
        @(posedge clk);
        while (!in_ready_o[p]) @(posedge clk);
        accepted[p]++;
    endtask

    task automatic release_input(input int p);
        #1;
        in_valid_i[p] = 1'b0;
    endtask

    task automatic send_packet(input int p, input logic [3:0] tx, input logic [3:0] ty,
                               input int len, input int max_gap);
        port_e dst;
        flit_t pkt [$];
        flit_t f;
        int    gap;
        dst = expected_port(tx, ty);
        for (int n = 0; n < len; n++) begin
            if (n == 0) begin
                f.data = {tx_seq[p], 5'd0, 3'(p), ty, tx};
            end else begin
                f.data = next_rand();
            end
            f.last = (n == len - 1);
            pkt.push_back(f);
            exp_q[int'(dst) * CHANNEL_NUMBER + p].push_back(f);
            pending_flits++;
        end
        tx_seq[p]++;
        foreach (pkt[n]) begin
            gap = 0;
            if (max_gap > 0 && rand_below(4) == 0) begin
                gap = 1 + rand_below(max_gap);
            end
            drive_flit(p, pkt[n], gap);
        end
    endtask

    task automatic drive_random_port(input int p);
        for (int k = 0; k < RANDOM_PACKETS; k++) begin
            send_packet(p, 4'(rand_below(MAX_ROUTERS_X)), 4'(rand_below(MAX_ROUTERS_Y)),
                        1 + rand_below(6), 3);
        end
        release_input(p);
    endtask

    task automatic drive_fair_port(input int p);
        for (int k = 0; k < FAIR_PACKETS; k++) begin
            send_packet(p, 4'(rand_below(MAX_ROUTERS_X)), 4'(rand_below(MAX_ROUTERS_Y)), 1, 0);
        end
        release_input(p);
    endtask

    task automatic wait_drain();
        do @(posedge clk); while (pending_flits != 0);
    endtask

    task automatic check_flit(input int j, input flit_t got_f, input flit_t exp_f);
        assert (got_f.data == exp_f.data)
            else abort_run($sformatf("Mismatch out_flit_o[%0d].data exp %h got %h",
                                     j, exp_f.data, got_f.data));
        assert (got_f.last == exp_f.last)
            else abort_run($sformatf("Mismatch out_flit_o[%0d].last exp %h got %h",
                                     j, exp_f.last, got_f.last));
    endtask

    ////////////////////////////////////////////////////////////
    // Output ready, scoreboard and timeout
    ////////////////////////////////////////////////////////////

    always begin
        @(posedge clk);
        #1;
        case (ready_mode)
            1:       out_ready_i = CHANNEL_NUMBER'(next_rand());
            2:       out_ready_i = '0;
            default: out_ready_i = '1;
        endcase
    end

    always @(posedge clk) begin
        int    src;
        flit_t got_f;
        flit_t exp_f;
        if (arst_n_i) begin
            for (int j = 0; j < CHANNEL_NUMBER; j++) begin
                if (out_valid_o[j] && out_ready_i[j]) begin
                    got_f = out_flit_o[j];
                    for (int k = 0; k < CHANNEL_NUMBER; k++) begin
                        assert (k == j || !mid[k])
                            else abort_run($sformatf(
                                "Output %0d moved a flit while output %0d was inside a packet",
                                j, k));
                    end
                    if (!mid[j]) begin
                        src = int'(got_f.data[10:8]);
                        assert (src < CHANNEL_NUMBER)
                            else abort_run($sformatf("Output %0d header names no valid input", j));
                        assert (got_f.data[31:16] == rx_seq[src])
                            else abort_run($sformatf(
                                "Mismatch out_flit_o[%0d].data sequence exp %h got %h",
                                j, rx_seq[src], got_f.data[31:16]));
                        rx_seq[src]  = rx_seq[src] + 16'd1;
                        cur_src[j]   = src;
                        pkt_count[j] = pkt_count[j] + 1;
                        if (fair_check) begin
                            assert (fair_prev < 0 || src == (fair_prev + 1) % CHANNEL_NUMBER)
                                else abort_run($sformatf(
                                    "Mismatch out_flit_o[%0d].data source exp %h got %h",
                                    j, (fair_prev + 1) % CHANNEL_NUMBER, src));
                            fair_prev = src;
                        end
                    end
                    src = cur_src[j];
                    assert (exp_q[j * CHANNEL_NUMBER + src].size() > 0)
                        else abort_run($sformatf("Output %0d delivered a flit input %0d never sent",
                                                 j, src));
                    exp_f = exp_q[j * CHANNEL_NUMBER + src].pop_front();
                    check_flit(j, got_f, exp_f);
                    mid[j]         = !got_f.last;
                    delivered[src] = delivered[src] + 1;
                    pending_flits  = pending_flits - 1;
                end
            end
        end
    end

    // A full buffer is the only reason for a low input ready.
    always @(negedge clk) begin
        if (arst_n_i) begin
            for (int i = 0; i < CHANNEL_NUMBER; i++) begin
                assert (in_ready_o[i] || accepted[i] - delivered[i] >= BUFFER_LENGTH)
                    else abort_run($sformatf("in_ready_o[%0d] dropped with %0d flits outstanding",
                                             i, accepted[i] - delivered[i]));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles with %0d flits still expected",
                                cycles, pending_flits));
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        for (int i = 0; i < CHANNEL_NUMBER; i++) begin
            in_flit_i[i] = '0;
            accepted[i]  = 0;
            delivered[i] = 0;
            pkt_count[i] = 0;
            cur_src[i]   = 0;
            mid[i]       = 1'b0;
            tx_seq[i]    = '0;
            rx_seq[i]    = '0;
        end
        in_valid_i    = '0;
        out_ready_i   = '1;
        arst_n_i      = 1'b0;
        pending_flits = 0;
        cycles        = 0;
        ready_mode    = 0;
        fair_check    = 1'b0;
        fair_prev     = -1;

        repeat (10) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        assert (out_valid_o == '0) else abort_run("An output is valid right after reset");
        assert (in_ready_o == '1) else abort_run("An input is not ready right after reset");
        @(posedge clk);

        // Directed targets around (1,2).
        send_packet(0, 4'd3, 4'd2, 2, 0);
        send_packet(0, 4'd2, 4'd0, 2, 0);
        send_packet(0, 4'd0, 4'd2, 2, 0);
        send_packet(0, 4'd0, 4'd3, 2, 0);
        send_packet(0, 4'd1, 4'd3, 2, 0);
        send_packet(0, 4'd1, 4'd0, 2, 0);
        send_packet(0, 4'd1, 4'd1, 2, 0);
        send_packet(0, 4'd1, 4'd2, 2, 0);
        send_packet(0, 4'd2, 4'd2, 2, 0);
        send_packet(0, 4'd1, 4'd2, 1, 0);
        release_input(0);
        wait_drain();
        for (int j = 0; j < CHANNEL_NUMBER; j++) begin
            assert (pkt_count[j] > 0)
                else abort_run($sformatf("Output %0d received no packet in the routing test", j));
        end

        // Bursty traffic against random back-pressure.
        ready_mode = 1;
        fork
            drive_random_port(0);
            drive_random_port(1);
            drive_random_port(2);
            drive_random_port(3);
            drive_random_port(4);
        join
        wait_drain();
        ready_mode = 0;

        // Fill every buffer, then release and watch the grant order.
        ready_mode = 2;
        fork
            drive_fair_port(0);
            drive_fair_port(1);
            drive_fair_port(2);
            drive_fair_port(3);
            drive_fair_port(4);
            begin
                wait (in_ready_o == '0);
                fair_check = 1'b1;
                ready_mode = 0;
            end
        join
        wait_drain();
        fair_check = 1'b0;
        assert (fair_prev >= 0) else abort_run("No packet was seen in the round-robin test");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: noc_router.f
source/noc_pkg.sv
source/flit_buffer.sv
source/packet_arbiter.sv
source/xy_routing.sv
source/noc_router.sv
test/tb_noc_router.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_noc_router \
    -f noc_router.f \
    -o sim_noc_router

# The log search below decides the result.
./obj_dir/sim_noc_router > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    exit 0
else
    exit 1
fi
